//--- filelist.f
src/ntm_pkg.sv
src/ntm_mac_if.sv
src/ntm_mac.sv
src/ntm_logistic.sv
src/ntm_sequencer.sv
src/ntm_controller.sv
tb/ntm_controller_asserts.sv
tb/ntm_controller_tb.sv

//--- Bender.yml
package:
  name: ntm_controller

sources:
  - src/ntm_pkg.sv
  - src/ntm_mac_if.sv
  - src/ntm_mac.sv
  - src/ntm_logistic.sv
  - src/ntm_sequencer.sv
  - src/ntm_controller.sv
  - target: test
    files:
      - tb/ntm_controller_asserts.sv
      - tb/ntm_controller_tb.sv

//--- tb/ntm_controller_tb.sv
// Testbench for the NTM controller cell
// LFSR operands, reference model of the Q8.8 step, per-test summary
`timescale 1ns/1ps

module ntm_controller_tb;

  localparam int VEC_LEN = 4;
  localparam int N_TESTS = 5;
  localparam int MAX_STEPS = 8;
  // Tests x steps x strobes x gap margin x period x 2
  localparam longint WATCHDOG_NS = N_TESTS * MAX_STEPS * (3 * VEC_LEN + 2) * 4 * 100 * 2;

  logic CLK;
  logic RST;
  logic start;
  logic in_enable;
  ntm_pkg::data_t a_in;
  ntm_pkg::data_t b_in;
  logic ready;
  ntm_pkg::data_t h_out;
  logic h_out_enable;

  // W, K, U then bias on a; x then r on b
  ntm_pkg::data_t a_seq[3*VEC_LEN+1];
  ntm_pkg::data_t b_seq[2*VEC_LEN];
  ntm_pkg::data_t model_h;
  logic [31:0] lfsr_state;
  int errors;
  int pass_cnt;
  int fail_cnt;
  int e0;
  int k;
  logic [31:0] rv;

  ntm_controller #(.VEC_LEN(VEC_LEN)) u_ntm_controller (
    .CLK(CLK), .RST(RST), .start(start), .in_enable(in_enable), .a_in(a_in), .b_in(b_in),
    .ready(ready), .h_out(h_out), .h_out_enable(h_out_enable)
  );

  bind ntm_controller ntm_controller_asserts u_asserts (
    .CLK(CLK), .RST(RST), .h_out(h_out), .h_out_enable(h_out_enable)
  );

  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Sign and magnitude, |v| below 2.0
  task automatic draw_small(output ntm_pkg::data_t v);
    logic [31:0] r;
    draw_bits(10, r);
    v = r[9] ? -ntm_pkg::data_t'({7'd0, r[8:0]}) : ntm_pkg::data_t'({7'd0, r[8:0]});
  endtask

  // Close to the data_t limits
  task automatic draw_big(input bit neg, output ntm_pkg::data_t v);
    logic [31:0] r;
    draw_bits(8, r);
    v = ntm_pkg::data_t'(16'h7f00 + r[7:0]);
    if (neg) begin
      v = -v;
    end
  endtask

  task automatic fill_small();
    int i;
    for (i = 0; i <= 3 * VEC_LEN; i++) begin
      draw_small(a_seq[i]);
    end
    for (i = 0; i < 2 * VEC_LEN; i++) begin
      draw_small(b_seq[i]);
    end
  endtask

  // Weights and bias share the sign, vector elements stay positive
  task automatic fill_extreme(input bit neg);
    int i;
    for (i = 0; i <= 3 * VEC_LEN; i++) begin
      draw_big(neg, a_seq[i]);
    end
    for (i = 0; i < 2 * VEC_LEN; i++) begin
      draw_big(1'b0, b_seq[i]);
    end
  endtask

  task automatic drive(input logic en, input ntm_pkg::data_t a, input ntm_pkg::data_t b,
                       input logic st);
    in_enable <= en;
    a_in      <= a;
    b_in      <= b;
    start     <= st;
  endtask

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  function automatic ntm_pkg::data_t model_next(input ntm_pkg::data_t h_prev);
    longint acc;
    longint t;
    int i;
    acc = 0;
    for (i = 0; i < 3 * VEC_LEN; i++) begin
      if (i < 2 * VEC_LEN) begin
        acc += longint'(a_seq[i]) * longint'(b_seq[i]);
      end else begin
        acc += longint'(a_seq[i]) * longint'(h_prev);
      end
    end
    // Bias up to Q16.16, back to Q8.8 with saturation
    t = (acc + (longint'(a_seq[3*VEC_LEN]) <<< ntm_pkg::FRAC_BITS)) >>> ntm_pkg::FRAC_BITS;
    if (t > 32767) begin
      t = 32767;
    end else if (t < -32768) begin
      t = -32768;
    end
    // Hard sigmoid
    t = (t >>> 2) + ntm_pkg::HALF_FIX;
    if (t < 0) begin
      t = 0;
    end else if (t > ntm_pkg::ONE_FIX) begin
      t = ntm_pkg::ONE_FIX;
    end
    return ntm_pkg::data_t'(t);
  endfunction

  task automatic compare_data(input string name, input ntm_pkg::data_t exp,
                              input ntm_pkg::data_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  // One full h(t) step, optional gaps and a stray start mid-step
  task automatic run_step(input bit with_gaps, input bit mid_start);
    ntm_pkg::data_t expected;
    logic [31:0] r;
    int idx;
    int gap;
    int waited;
    bit seen;
    expected = model_next(model_h);
    @(posedge CLK);
    drive(1'b0, '0, '0, 1'b1);
    for (idx = 0; idx <= 3 * VEC_LEN; idx++) begin
      gap = 0;
      if (with_gaps) begin
        draw_bits(2, r);
        gap = r[1:0];
      end
      repeat (gap) begin
        @(posedge CLK);
        draw_bits(16, r);
        drive(1'b0, r[15:0], r[15:0], 1'b0);
      end
      // Random b_in where the DUT ignores it
      draw_bits(16, r);
      @(posedge CLK);
      drive(1'b1, a_seq[idx], (idx < 2 * VEC_LEN) ? b_seq[idx] : r[15:0],
            mid_start && (idx == VEC_LEN + 1));
    end
    // Edge n samples the bias
    @(posedge CLK);
    drive(1'b0, '0, '0, 1'b0);
    waited = 0;
    seen = 0;
    while (!seen && waited < 8) begin
      @(negedge CLK);
      waited++;
      seen = h_out_enable;
      // Still busy between the bias edge and the result
      if (waited == 1) begin
        compare_bit("ready at edge n", 1'b0, ready);
      end
    end
    if (!seen) begin
      $display("No h_out_enable pulse arrived after the bias strobe at %0t", $time);
      errors++;
    end else begin
      compare_bit("h_out_enable at edge n+1", 1'b1, waited == 2);
      compare_bit("ready", 1'b1, ready);
      compare_data("h_out", expected, h_out);
      @(negedge CLK);
      compare_bit("h_out_enable", 1'b0, h_out_enable);
    end
    model_h = expected;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    RST = 1'b1;
    start = 1'b0;
    in_enable = 1'b0;
    a_in = '0;
    b_in = '0;
    lfsr_state = 32'h2f88;
    model_h = '0;
    errors = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    e0 = errors;
    @(negedge CLK);
    compare_bit("ready", 1'b1, ready);
    compare_bit("h_out_enable", 1'b0, h_out_enable);
    compare_data("h_out", '0, h_out);
    report_test("reset", e0);
    e0 = errors;
    fill_small();
    run_step(1'b0, 1'b0);
    report_test("single step", e0);
    e0 = errors;
    repeat (MAX_STEPS) begin
      fill_small();
      run_step(1'b1, 1'b0);
    end
    report_test("recurrence", e0);
    e0 = errors;
    fill_extreme(1'b0);
    run_step(1'b1, 1'b0);
    fill_extreme(1'b1);
    run_step(1'b1, 1'b0);
    report_test("saturation", e0);
    // Strobes while idle, then a second start inside the step
    e0 = errors;
    for (k = 0; k < 3; k++) begin
      draw_bits(32, rv);
      @(posedge CLK);
      drive(1'b1, rv[15:0], rv[31:16], 1'b0);
    end
    fill_small();
    run_step(1'b1, 1'b1);
    report_test("ignored inputs", e0);
    $display("tests passed %0d, failed %0d, assertion failures %0d", pass_cnt, fail_cnt,
             u_ntm_controller.u_asserts.fail_count);
    if ((fail_cnt == 0) && (u_ntm_controller.u_asserts.fail_count == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- tb/ntm_controller_asserts.sv
// Output protocol checks for the NTM controller cell
// One pulse per step, h_out in range on the pulse
`timescale 1ns/1ps

module ntm_controller_asserts (
  input logic           CLK,
  input logic           RST,
  input ntm_pkg::data_t h_out,
  input logic           h_out_enable
);

  // Failed assertions so far
  int fail_count = 0;

  // Output is a single-cycle pulse
  pulse_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    h_out_enable |=> !h_out_enable)
    else begin
      $error("h_out_enable high for two cycles");
      fail_count++;
    end

  // Logistic range 0 to 1.0
  h_in_range: assert property (@(posedge CLK) disable iff (RST)
    h_out_enable |-> (h_out >= 0) && (h_out <= ntm_pkg::ONE_FIX))
    else begin
      $error("h_out outside 0 to 1.0");
      fail_count++;
    end

  // Quiet in reset and in the cycle after release
  quiet_in_reset: assert property (@(posedge CLK) RST |-> !h_out_enable)
    else begin
      $error("h_out_enable high in reset");
      fail_count++;
    end
  quiet_after_reset: assert property (@(posedge CLK)
    $fell(RST) |-> !h_out_enable ##1 !h_out_enable)
    else begin
      $error("h_out_enable high right after reset");
      fail_count++;
    end

endmodule

//--- src/ntm_controller.sv
// NTM controller cell, top level
// h(t) = logistic(W.x + K.r + U.h(t-1) + b) for one element in Q8.8,
// operands streamed on a plain strobe
`timescale 1ns/1ps

module ntm_controller #(
  parameter int VEC_LEN = 4
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           start,
  input  logic           in_enable,
  input  ntm_pkg::data_t a_in,
  input  ntm_pkg::data_t b_in,
  output logic           ready,
  output ntm_pkg::data_t h_out,
  output logic           h_out_enable
);

  //////////////////////////////////////////////////
  // Internal links
  //////////////////////////////////////////////////

  ntm_mac_if u_mac_if ();

  // Sequencer to logistic
  ntm_pkg::data_t z;
  logic           z_valid;
  ntm_pkg::data_t y;
  logic           y_valid;

  ntm_sequencer #(
    .VEC_LEN(VEC_LEN)
  ) u_sequencer (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .in_enable(in_enable),
    .a_in     (a_in),
    .b_in     (b_in),
    .ready    (ready),
    .mac      (u_mac_if.seq),
    .z        (z),
    .z_valid  (z_valid),
    .y        (y),
    .y_valid  (y_valid)
  );

  ntm_mac u_mac (
    .CLK(CLK),
    .RST(RST),
    .mac(u_mac_if.mac)
  );

  ntm_logistic u_logistic (
    .CLK    (CLK),
    .RST    (RST),
    .z      (z),
    .z_valid(z_valid),
    .y      (y),
    .y_valid(y_valid)
  );

  // Logistic result is h(t), also fed back to the sequencer
  assign h_out        = y;
  assign h_out_enable = y_valid;

endmodule

//--- src/ntm_sequencer.sv
// Step sequencer of the NTM controller cell
// Walks the W.x, K.r and U.h phases, adds the bias, feeds the logistic
// and keeps h(t-1) for the next step
`timescale 1ns/1ps

module ntm_sequencer #(
  parameter int VEC_LEN = 4
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           start,
  input  logic           in_enable,
  input  ntm_pkg::data_t a_in,
  input  ntm_pkg::data_t b_in,
  output logic           ready,
  ntm_mac_if.seq         mac,
  output ntm_pkg::data_t z,
  output logic           z_valid,
  input  ntm_pkg::data_t y,
  input  logic           y_valid
);

  //////////////////////////////////////////////////
  // Local constants and state
  //////////////////////////////////////////////////

  localparam int CNT_W = (VEC_LEN > 1) ? $clog2(VEC_LEN) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(VEC_LEN - 1);

  // Saturation limits of z in accumulator width
  localparam ntm_pkg::acc_t Z_MAX = ntm_pkg::acc_t'(2**(ntm_pkg::DATA_W-1) - 1);
  localparam ntm_pkg::acc_t Z_MIN = ntm_pkg::acc_t'(-(2**(ntm_pkg::DATA_W-1)));

  ntm_pkg::step_e state;
  logic [CNT_W-1:0] cnt;
  // h(t-1), zero until the first step completes
  ntm_pkg::data_t h_prev;

  logic conv_phase;
  logic last_pair;
  ntm_pkg::acc_t biased;
  ntm_pkg::acc_t shifted;
  ntm_pkg::data_t z_sat;

  //////////////////////////////////////////////////
  // Operand routing
  //////////////////////////////////////////////////

  assign conv_phase = (state == ntm_pkg::CONV_WX) || (state == ntm_pkg::CONV_KR) ||
                      (state == ntm_pkg::CONV_UH);
  assign last_pair  = (cnt == CNT_LAST);
  assign ready      = (state == ntm_pkg::IDLE);

  // Clear lands on the same edge that takes start
  assign mac.clear  = ready && start;
  assign mac.enable = conv_phase && in_enable;
  assign mac.a      = a_in;
  // U pairs with the held h, b_in unused there
  assign mac.b      = (state == ntm_pkg::CONV_UH) ? h_prev : b_in;

  //////////////////////////////////////////////////
  // Bias and saturation
  //////////////////////////////////////////////////

  always_comb begin
    // Bias brought up to Q16.16 before the add
    biased  = mac.sum + (ntm_pkg::acc_t'(a_in) <<< ntm_pkg::FRAC_BITS);
    shifted = biased >>> ntm_pkg::FRAC_BITS;
    if (shifted > Z_MAX) begin
      z_sat = ntm_pkg::data_t'(Z_MAX);
    end else if (shifted < Z_MIN) begin
      z_sat = ntm_pkg::data_t'(Z_MIN);
    end else begin
      z_sat = ntm_pkg::data_t'(shifted);
    end
  end

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ntm_pkg::IDLE: begin
          cnt <= '0;
          if (start) begin
            state <= ntm_pkg::CONV_WX;
          end
        end
        ntm_pkg::CONV_WX, ntm_pkg::CONV_KR, ntm_pkg::CONV_UH: begin
          // Waits through gaps, advances on the last pair
          if (in_enable) begin
            if (last_pair) begin
              cnt <= '0;
              case (state)
                ntm_pkg::CONV_WX: state <= ntm_pkg::CONV_KR;
                ntm_pkg::CONV_KR: state <= ntm_pkg::CONV_UH;
                default:          state <= ntm_pkg::ADD_BIAS;
              endcase
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        ntm_pkg::ADD_BIAS: begin
          if (in_enable) begin
            state <= ntm_pkg::LOGISTIC;
          end
        end
        // z is in the logistic now
        default: begin
          state <= ntm_pkg::IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // z handoff and recurrent state
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      z_valid <= 1'b0;
      h_prev  <= '0;
    end else begin
      z_valid <= (state == ntm_pkg::ADD_BIAS) && in_enable;
      // New h(t-1) once the logistic result arrives
      if (y_valid) begin
        h_prev <= y;
      end
    end
  end

  // Sampled together with the bias strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      z <= '0;
    end else if ((state == ntm_pkg::ADD_BIAS) && in_enable) begin
      z <= z_sat;
    end
  end

endmodule

//--- src/ntm_logistic.sv
// Hard-sigmoid logistic unit
// y = z/4 + 1/2 clamped to 0 through 1.0, registered, one cycle latency
`timescale 1ns/1ps

module ntm_logistic (
  input  logic           CLK,
  input  logic           RST,
  input  ntm_pkg::data_t z,
  input  logic           z_valid,
  output ntm_pkg::data_t y,
  output logic           y_valid
);

  // Unclamped slope and offset
  ntm_pkg::data_t lin;
  ntm_pkg::data_t clamped;

  always_comb begin
    // Quarter slope plus half, no overflow in 16 bits
    lin = (z >>> 2) + ntm_pkg::HALF_FIX;
    if (lin < 0) begin
      clamped = '0;
    end else if (lin > ntm_pkg::ONE_FIX) begin
      clamped = ntm_pkg::ONE_FIX;
    end else begin
      clamped = lin;
    end
  end

  // Result held until the next z, pulse on y_valid
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      y       <= '0;
      y_valid <= 1'b0;
    end else begin
      y_valid <= z_valid;
      if (z_valid) begin
        y <= clamped;
      end
    end
  end

endmodule

//--- src/ntm_mac.sv
// Multiply-accumulate unit of the NTM controller cell
// Sums a*b over the W.x, K.r and U.h phases into one Q16.16 accumulator
`timescale 1ns/1ps

module ntm_mac (
  input logic CLK,
  input logic RST,
  ntm_mac_if.mac mac
);

  //////////////////////////////////////////////////
  // Product
  //////////////////////////////////////////////////

  // Full-width signed product, Q16.16
  logic signed [2*ntm_pkg::DATA_W-1:0] prod;

  always_comb begin
    // Operands widen to the product width before the multiply
    prod = mac.a * mac.b;
  end

  //////////////////////////////////////////////////
  // Accumulator
  //////////////////////////////////////////////////

  // Clear wins over enable, the sequencer never raises both
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mac.sum <= '0;
    end else if (mac.clear) begin
      mac.sum <= '0;
    end else if (mac.enable) begin
      // Sign extended product added to the sum
      mac.sum <= mac.sum + ntm_pkg::acc_t'(prod);
    end
  end

endmodule

//--- src/ntm_mac_if.sv
// Operand and accumulator link between the sequencer and the MAC
// Sequencer supplies the pair and the strobes, MAC returns the running sum
`timescale 1ns/1ps

interface ntm_mac_if;

  // Zero the sum at the start of a step
  logic clear;
  // One product per cycle while high
  logic enable;
  ntm_pkg::data_t a;
  ntm_pkg::data_t b;
  // Running sum, Q16.16 scaled
  ntm_pkg::acc_t sum;

  modport seq (
    output clear, enable, a, b,
    input  sum
  );

  modport mac (
    input  clear, enable, a, b,
    output sum
  );

endinterface

//--- src/ntm_pkg.sv
// NTM controller cell shared definitions
// Q8.8 fixed-point types, sequencer states and fixed-point constants
package ntm_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // One operand, one h element
  localparam int DATA_W = 16;
  // Q8.8 fraction
  localparam int FRAC_BITS = 8;
  // Room for 256 Q16.16 products plus the bias
  localparam int ACC_W = 40;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // Sequencer steps, one per phase of h(t)
  typedef enum logic [2:0] {
    IDLE,
    CONV_WX,
    CONV_KR,
    CONV_UH,
    ADD_BIAS,
    LOGISTIC
  } step_e;

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  // 1.0 and 0.5 in Q8.8
  localparam data_t ONE_FIX = 16'sd256;
  localparam data_t HALF_FIX = 16'sd128;

endpackage
